// ==== ctrlOutput.sv ====
module ctrlOutput
    import isaPkg::*, ctrlPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,

    input  logic                 aluEnableNext,
    input  logic [nibbleW-1:0]   aluOpNext,
    input  logic [nibbleW-1:0]   aluSubOpNext,
    input  logic                 accWeNext,
    input  logic                 tempWeNext,
    input  logic                 regWeNext,
    input  logic                 regSrcSelNext,
    input  aluSelT               aluSelNext,
    input  logic                 pairWeNext,
    input  logic [pairAddrW-1:0] pairAddrNext,
    input  logic [2*nibbleW-1:0] pairDinNext,
    input  logic                 needImmNext,
    input  logic                 finImmNext,
    input  logic                 jumpNext,
    input  logic                 jumpCondNext,
    input  logic [addrW-1:0]     pcLoadDataNext,
    input  logic                 stackPushNext,
    input  logic                 stackPopNext,
    input  logic                 pcLoadUsePairNext,
    input  logic                 ccOut,

    output logic                 aluEnable,
    output logic [nibbleW-1:0]   aluOp,
    output logic [nibbleW-1:0]   aluSubOp,
    output logic                 accWe,
    output logic                 tempWe,
    output logic                 regWe,
    output logic                 regSrcSel,
    output aluSelT               aluSel,
    output logic                 pairWe,
    output logic [pairAddrW-1:0] pairAddr,
    output logic [2*nibbleW-1:0] pairDin,
    output logic                 needImm,
    output logic                 finImm,
    output logic                 pcLoad,
    output logic [addrW-1:0]     pcLoadData,
    output logic                 stackPush,
    output logic                 stackPop,
    output logic                 pcLoadUsePair
);

    logic loadNow;

    // Unconditional jump or JCN taken
    assign loadNow = jumpNext | (jumpCondNext & ccOut);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluEnable     <= 1'b0;
            aluOp         <= '0;
            aluSubOp      <= '0;
            accWe         <= 1'b0;
            tempWe        <= 1'b0;
            regWe         <= 1'b0;
            regSrcSel     <= 1'b0;
            aluSel        <= selReg;
            pairWe        <= 1'b0;
            pairAddr      <= '0;
            pairDin       <= '0;
            needImm       <= 1'b0;
            finImm        <= 1'b0;
            pcLoad        <= 1'b0;
            pcLoadData    <= '0;
            stackPush     <= 1'b0;
            stackPop      <= 1'b0;
            pcLoadUsePair <= 1'b0;
        end else begin
            aluEnable     <= aluEnableNext;
            aluOp         <= aluOpNext;
            aluSubOp      <= aluSubOpNext;
            accWe         <= accWeNext;
            tempWe        <= tempWeNext;
            regWe         <= regWeNext;
            regSrcSel     <= regSrcSelNext;
            aluSel        <= aluSelNext;
            pairWe        <= pairWeNext;
            pairAddr      <= pairAddrNext;
            pairDin       <= pairDinNext;
            needImm       <= needImmNext;
            finImm        <= finImmNext;
            pcLoad        <= loadNow;
            pcLoadData    <= loadNow ? pcLoadDataNext : '0;
            stackPush     <= stackPushNext;
            stackPop      <= stackPopNext;
            pcLoadUsePair <= pcLoadUsePairNext;
        end
    end

endmodule

// ==== ctrlPkg.sv ====
package ctrlPkg;

    // ----------------------------------------
    // ALU operand source
    // ----------------------------------------
    typedef enum logic [1:0] {
        selReg  = 2'b00,
        selImm  = 2'b01,
        selNone = 2'b11   // Idle between instructions
    } aluSelT;

    // ----------------------------------------
    // Flag update requests
    // ----------------------------------------
    typedef enum logic [2:0] {
        cKeep,
        cAlu,
        cClear,
        cSet,
        cInvert
    } carryUpdT;

    typedef enum logic [0:0] {
        zKeep,
        zAlu
    } zeroUpdT;

    localparam int pairAddrW = 4;

endpackage

// ==== decoderTop.f ====
+incdir+.
isaPkg.sv
ctrlPkg.sv
instrDecode.sv
flagUnit.sv
ctrlOutput.sv
decoderTop.sv
decoderTop_tb.sv

// ==== decoderTop.sv ====
module decoderTop
    import isaPkg::*, ctrlPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [nibbleW-1:0]   opr,
    input  logic [nibbleW-1:0]   opa,
    input  logic [cycleW-1:0]    cycle,
    input  logic                 carryFromAlu,
    input  logic                 zeroFromAlu,
    input  logic                 testFlag,
    input  logic                 immFetchActive,  // Second word in flight
    input  logic [addrW-1:0]     immAddr,

    output logic                 aluEnable,
    output logic [nibbleW-1:0]   aluOp,
    output logic [nibbleW-1:0]   aluSubOp,
    output logic                 accWe,
    output logic                 tempWe,
    output logic                 regWe,
    output logic                 regSrcSel,
    output aluSelT               aluSel,
    output logic                 pairWe,
    output logic [pairAddrW-1:0] pairAddr,
    output logic [2*nibbleW-1:0] pairDin,
    output logic                 needImm,
    output logic                 finImm,
    output logic                 pcLoad,
    output logic [addrW-1:0]     pcLoadData,
    output logic                 stackPush,
    output logic                 stackPop,
    output logic                 pcLoadUsePair,
    output logic                 carryFlag,
    output logic                 zeroFlag,
    output logic                 ccOut
);

    // ----------------------------------------
    // Decode results for the next edge
    // ----------------------------------------
    logic                 aluEnableNext;
    logic [nibbleW-1:0]   aluOpNext;
    logic [nibbleW-1:0]   aluSubOpNext;
    logic                 accWeNext;
    logic                 tempWeNext;
    logic                 regWeNext;
    logic                 regSrcSelNext;
    aluSelT               aluSelNext;
    logic                 pairWeNext;
    logic [pairAddrW-1:0] pairAddrNext;
    logic [2*nibbleW-1:0] pairDinNext;
    logic                 needImmNext;
    logic                 finImmNext;
    logic                 jumpNext;
    logic                 jumpCondNext;
    logic [addrW-1:0]     pcLoadDataNext;
    logic                 stackPushNext;
    logic                 stackPopNext;
    logic                 pcLoadUsePairNext;
    carryUpdT             carryUpd;
    zeroUpdT              zeroUpd;

    instrDecode i_instrDecode (.*);

    flagUnit i_flagUnit (.*);

    ctrlOutput i_ctrlOutput (.*);

endmodule

// ==== tbModel.svh ====
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

// Expected DUT outputs after one rising edge
typedef struct packed {
    logic                 aluEnable;
    logic [nibbleW-1:0]   aluOp;
    logic [nibbleW-1:0]   aluSubOp;
    logic                 accWe;
    logic                 tempWe;
    logic                 regWe;
    logic                 regSrcSel;
    aluSelT               aluSel;
    logic                 pairWe;
    logic [pairAddrW-1:0] pairAddr;
    logic [2*nibbleW-1:0] pairDin;
    logic                 needImm;
    logic                 finImm;
    logic                 pcLoad;
    logic [addrW-1:0]     pcLoadData;
    logic                 stackPush;
    logic                 stackPop;
    logic                 pcLoadUsePair;
    logic                 carryFlag;
    logic                 zeroFlag;
} expOutT;

expOutT expOut;
logic   modelCarry;
logic   modelZero;
logic   testHist1;  // TEST at the last edge
logic   testHist2;  // Two edges back as JCN sees it

// JCN condition with bit 3 as invert
function automatic logic condCode(input logic [3:0] cond, input logic c, input logic z,
                                  input logic t);
    logic hit;
    hit = (cond[0] && !t) || (cond[1] && c) || (cond[2] && z);
    return cond[3] ? !hit : hit;
endfunction

function automatic expOutT resetOutputs();
    expOutT e;
    e        = '0;
    e.aluSel = selReg;
    return e;
endfunction

task automatic resetModel();
    modelCarry = 1'b0;
    modelZero  = 1'b0;
    testHist1  = 1'b0;
    testHist2  = 1'b0;
endtask

// Flags follow the prediction and TEST shifts by one
task automatic advanceModel(input expOutT e, input logic t);
    modelCarry = e.carryFlag;
    modelZero  = e.zeroFlag;
    testHist2  = testHist1;
    testHist1  = t;
endtask

// ----------------------------------------
// Reference decode
// ----------------------------------------
function automatic expOutT predictOutputs(
    input logic [nibbleW-1:0] op,
    input logic [nibbleW-1:0] sub,
    input logic [cycleW-1:0]  cyc,
    input logic               immValid,
    input logic [addrW-1:0]   addr,
    input logic               aluC,
    input logic               aluZ
);
    expOutT e;
    logic   x3;
    logic   pairOp;   // FIM/SRC or FIN/JIN code
    logic   twoWord;
    logic   taken;
    e           = '0;
    e.aluSel    = selNone;
    e.carryFlag = modelCarry;
    e.zeroFlag  = modelZero;
    e.tempWe    = (cyc == cycX1);
    x3          = (cyc == cycX3);
    pairOp      = (op == oprFimSrc) || (op == oprFinJin);
    twoWord     = (op inside {oprJcn, oprJun, oprJms}) || (pairOp && !sub[0]);
    taken       = 1'b0;

    if (op inside {oprInc, oprAdd, oprSub, oprLd, oprXch, oprBbl, oprLdm, oprAccGrp}) begin
        e.aluEnable = 1'b1;
        e.aluOp     = (op == oprXch) ? oprLd : op;  // XCH runs as LD
    end
    if (op inside {oprBbl, oprLdm}) begin
        e.aluSel = selImm;
    end else if ((op == oprXch) || (x3 && (op inside {oprInc, oprAdd, oprSub, oprLd}))) begin
        e.aluSel = selReg;
    end
    if (x3) begin
        e.regWe     = (op inside {oprInc, oprXch});
        e.accWe     = (op inside {oprAdd, oprSub, oprLd, oprLdm, oprXch, oprBbl});
        e.regSrcSel = (op == oprXch);
        e.stackPop  = (op == oprBbl);
        if (op inside {oprInc, oprAdd, oprSub}) e.carryFlag = aluC;
        if (op inside {oprInc, oprAdd, oprSub, oprLd, oprLdm, oprXch}) e.zeroFlag = aluZ;
    end

    if (op == oprAccGrp) begin
        e.aluSubOp = sub;
        if (x3) begin
            e.accWe = !(sub inside {opaClc, opaCmc, opaStc, 4'hD, 4'hE, 4'hF});
            if (sub inside {opaClb, opaClc, opaTcc, opaTcs}) e.carryFlag = 1'b0;
            if (sub == opaCmc) e.carryFlag = !modelCarry;
            if (sub == opaStc) e.carryFlag = 1'b1;
            if (sub inside {opaIac, opaRal, opaRar, opaDac, opaDaa}) e.carryFlag = aluC;
            if (sub inside {opaClb, opaIac, opaCma, opaTcc, opaDac, opaDaa, opaKbp}) begin
                e.zeroFlag = aluZ;
            end
        end
    end

    // Two-word handshake and pair selects
    e.needImm = twoWord && x3 && !immValid;
    e.finImm  = e.needImm && (op == oprFinJin);
    if (pairOp && sub[0]) begin
        if (cyc == cycX1) e.pairAddr = {sub[3:1], 1'b0};
        e.pcLoadUsePair = x3 && (op == oprFinJin);
    end
    if (x3 && immValid) begin
        if (pairOp && !sub[0]) begin
            e.pairWe   = 1'b1;
            e.pairAddr = {sub[3:1], 1'b0};
            e.pairDin  = addr[7:0];
        end
        taken = (op inside {oprJun, oprJms})
            || ((op == oprJcn) && condCode(sub, modelCarry, modelZero, testHist2));
        e.stackPush = (op == oprJms);
    end
    e.pcLoad     = taken;
    e.pcLoadData = taken ? addr : '0;
    return e;
endfunction

`endif

// ==== decoderTop_tb.sv ====
module decoderTop_tb
    import isaPkg::*, ctrlPkg::*;
();

    localparam int clkPeriod    = 10;
    localparam int resetCycles  = 8;
    localparam int numVectors   = 5000;
    localparam int seed         = 36;
    localparam int watchdogTime = (numVectors + resetCycles + 100) * clkPeriod;

    logic                 clk;
    logic                 rstN;
    logic [nibbleW-1:0]   opr;
    logic [nibbleW-1:0]   opa;
    logic [cycleW-1:0]    cycle;
    logic                 carryFromAlu;
    logic                 zeroFromAlu;
    logic                 testFlag;
    logic                 immFetchActive;
    logic [addrW-1:0]     immAddr;
    logic                 aluEnable;
    logic [nibbleW-1:0]   aluOp;
    logic [nibbleW-1:0]   aluSubOp;
    logic                 accWe;
    logic                 tempWe;
    logic                 regWe;
    logic                 regSrcSel;
    aluSelT               aluSel;
    logic                 pairWe;
    logic [pairAddrW-1:0] pairAddr;
    logic [2*nibbleW-1:0] pairDin;
    logic                 needImm;
    logic                 finImm;
    logic                 pcLoad;
    logic [addrW-1:0]     pcLoadData;
    logic                 stackPush;
    logic                 stackPop;
    logic                 pcLoadUsePair;
    logic                 carryFlag;
    logic                 zeroFlag;
    logic                 ccOut;
    int                   checkCount = 0;

    `include "tbModel.svh"

    decoderTop i_decoderTop (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkField(input string name, input logic [11:0] expVal,
                              input logic [11:0] actVal);
        assert (actVal === expVal) else begin
            $display("Error in test %s at check %0d: expected %0h, actual %0h",
                     name, checkCount, expVal, actVal);
            $display(">>> FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic compareOutputs();
        checkField("aluEnable", 12'(expOut.aluEnable), 12'(aluEnable));
        checkField("aluOp", 12'(expOut.aluOp), 12'(aluOp));
        checkField("aluSubOp", 12'(expOut.aluSubOp), 12'(aluSubOp));
        checkField("accWe", 12'(expOut.accWe), 12'(accWe));
        checkField("tempWe", 12'(expOut.tempWe), 12'(tempWe));
        checkField("regWe", 12'(expOut.regWe), 12'(regWe));
        checkField("regSrcSel", 12'(expOut.regSrcSel), 12'(regSrcSel));
        checkField("aluSel", 12'(expOut.aluSel), 12'(aluSel));
        checkField("pairWe", 12'(expOut.pairWe), 12'(pairWe));
        checkField("pairAddr", 12'(expOut.pairAddr), 12'(pairAddr));
        checkField("pairDin", 12'(expOut.pairDin), 12'(pairDin));
        checkField("needImm", 12'(expOut.needImm), 12'(needImm));
        checkField("finImm", 12'(expOut.finImm), 12'(finImm));
        checkField("pcLoad", 12'(expOut.pcLoad), 12'(pcLoad));
        checkField("pcLoadData", expOut.pcLoadData, pcLoadData);
        checkField("stackPush", 12'(expOut.stackPush), 12'(stackPush));
        checkField("stackPop", 12'(expOut.stackPop), 12'(stackPop));
        checkField("pcLoadUsePair", 12'(expOut.pcLoadUsePair), 12'(pcLoadUsePair));
        checkField("carryFlag", 12'(expOut.carryFlag), 12'(carryFlag));
        checkField("zeroFlag", 12'(expOut.zeroFlag), 12'(zeroFlag));
        checkField("ccOut", 12'(condCode(opa, modelCarry, modelZero, testHist2)), 12'(ccOut));
    endtask

    // ----------------------------------------
    // Predict at the edge and compare just after
    // ----------------------------------------
    always begin
        @(posedge clk);
        if (!rstN) begin
            resetModel();
            expOut = resetOutputs();
        end else begin
            expOut = predictOutputs(opr, opa, cycle, immFetchActive, immAddr,
                                    carryFromAlu, zeroFromAlu);
            advanceModel(expOut, testFlag);
        end
        #1;
        compareOutputs();
        checkCount++;
    end

    initial begin
        int unsigned pick;
        rstN           = 1'b0;
        opr            = '0;
        opa            = '0;
        cycle          = '0;
        carryFromAlu   = 1'b0;
        zeroFromAlu    = 1'b0;
        testFlag       = 1'b0;
        immFetchActive = 1'b0;
        immAddr        = '0;
        void'($urandom(seed));
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < numVectors; i++) begin
            opr            = 4'($urandom);
            opa            = 4'($urandom);
            pick           = $urandom % 4;  // Half the vectors on X1 or X3
            cycle          = (pick == 0) ? cycX1 : ((pick == 1) ? cycX3 : 3'($urandom));
            immFetchActive = 1'($urandom);
            immAddr        = 12'($urandom);
            carryFromAlu   = 1'($urandom);
            zeroFromAlu    = 1'($urandom);
            testFlag       = 1'($urandom);
            @(negedge clk);
        end
        @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdogTime);
        $display("Timeout: run did not finish within %0d time units", watchdogTime);
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== flagUnit.sv ====
module flagUnit
    import isaPkg::*, ctrlPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  carryUpdT           carryUpd,
    input  zeroUpdT            zeroUpd,
    input  logic               carryFromAlu,
    input  logic               zeroFromAlu,
    input  logic               testFlag,   // External TEST pin
    input  logic [nibbleW-1:0] opa,
    output logic               carryFlag,
    output logic               zeroFlag,
    output logic               ccOut
);

    logic testSync1;
    logic testSync2;
    logic ccRaw;

    // ----------------------------------------
    // Flag registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            carryFlag <= 1'b0;
            zeroFlag  <= 1'b0;
        end else begin
            case (carryUpd)
                cAlu:    carryFlag <= carryFromAlu;
                cClear:  carryFlag <= 1'b0;
                cSet:    carryFlag <= 1'b1;
                cInvert: carryFlag <= ~carryFlag;
                default: carryFlag <= carryFlag;
            endcase
            if (zeroUpd == zAlu) begin
                zeroFlag <= zeroFromAlu;
            end
        end
    end

    // TEST is asynchronous to the core
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            testSync1 <= 1'b0;
            testSync2 <= 1'b0;
        end else begin
            testSync1 <= testFlag;
            testSync2 <= testSync1;
        end
    end

    // ----------------------------------------
    // JCN condition
    // ----------------------------------------
    always_comb begin
        ccRaw = (~testSync2 & opa[0])
              | (carryFlag  & opa[1])
              | (zeroFlag   & opa[2]);
        ccOut = opa[3] ? ~ccRaw : ccRaw;  // Invert bit
    end

endmodule

// ==== instrDecode.sv ====
module instrDecode
    import isaPkg::*, ctrlPkg::*;
(
    input  logic [nibbleW-1:0]   opr,
    input  logic [nibbleW-1:0]   opa,
    input  logic [cycleW-1:0]    cycle,
    input  logic                 immFetchActive,
    input  logic [addrW-1:0]     immAddr,

    output logic                 aluEnableNext,
    output logic [nibbleW-1:0]   aluOpNext,
    output logic [nibbleW-1:0]   aluSubOpNext,
    output logic                 accWeNext,
    output logic                 tempWeNext,
    output logic                 regWeNext,
    output logic                 regSrcSelNext,
    output aluSelT               aluSelNext,
    output logic                 pairWeNext,
    output logic [pairAddrW-1:0] pairAddrNext,
    output logic [2*nibbleW-1:0] pairDinNext,
    output logic                 needImmNext,
    output logic                 finImmNext,
    output logic                 jumpNext,
    output logic                 jumpCondNext,
    output logic [addrW-1:0]     pcLoadDataNext,
    output logic                 stackPushNext,
    output logic                 stackPopNext,
    output logic                 pcLoadUsePairNext,
    output carryUpdT             carryUpd,
    output zeroUpdT              zeroUpd
);

    logic                 isX1;
    logic                 isX3;
    logic                 firstX3;   // Second word still to come
    logic                 secondX3;  // Second word present
    logic [pairAddrW-1:0] evenPair;

    assign isX1     = (cycle == cycX1);
    assign isX3     = (cycle == cycX3);
    assign firstX3  = isX3 && !immFetchActive;
    assign secondX3 = isX3 && immFetchActive;
    assign evenPair = {opa[3:1], 1'b0};

    always_comb begin
        aluEnableNext     = 1'b0;
        aluOpNext         = '0;
        aluSubOpNext      = '0;
        accWeNext         = 1'b0;
        tempWeNext        = isX1;  // Temp <- ACC for every instruction
        regWeNext         = 1'b0;
        regSrcSelNext     = 1'b0;
        aluSelNext        = selNone;
        pairWeNext        = 1'b0;
        pairAddrNext      = '0;
        pairDinNext       = '0;
        needImmNext       = 1'b0;
        finImmNext        = 1'b0;
        jumpNext          = 1'b0;
        jumpCondNext      = 1'b0;
        stackPushNext     = 1'b0;
        stackPopNext      = 1'b0;
        pcLoadUsePairNext = 1'b0;
        carryUpd          = cKeep;
        zeroUpd           = zKeep;

        case (opr)
            oprJcn: begin
                needImmNext  = firstX3;
                jumpCondNext = secondX3;  // Resolved against ccOut later
            end

            oprFimSrc, oprFinJin: begin
                if (!opa[0]) begin
                    // FIM / FIN load the pair from the second word
                    needImmNext = firstX3;
                    finImmNext  = firstX3 && (opr == oprFinJin);
                    if (secondX3) begin
                        pairWeNext   = 1'b1;
                        pairAddrNext = evenPair;
                        pairDinNext  = immAddr[2*nibbleW-1:0];
                    end
                end else begin
                    if (isX1) begin
                        pairAddrNext = evenPair;  // SRC / JIN pair select
                    end
                    pcLoadUsePairNext = isX3 && (opr == oprFinJin);
                end
            end

            oprJun, oprJms: begin
                needImmNext   = firstX3;
                jumpNext      = secondX3;
                stackPushNext = secondX3 && (opr == oprJms);
            end

            oprInc, oprAdd, oprSub, oprLd: begin
                aluEnableNext = 1'b1;
                aluOpNext     = opr;
                if (isX3) begin
                    aluSelNext = selReg;
                    zeroUpd    = zAlu;
                    if (opr == oprInc) begin
                        regWeNext = 1'b1;
                    end else begin
                        accWeNext = 1'b1;
                    end
                    if (opr != oprLd) begin
                        carryUpd = cAlu;
                    end
                end
            end

            oprXch: begin
                aluEnableNext = 1'b1;
                aluOpNext     = oprLd;   // Reg passes through ALU for Z
                aluSelNext    = selReg;
                if (isX3) begin
                    accWeNext     = 1'b1;
                    regWeNext     = 1'b1;
                    regSrcSelNext = 1'b1;  // Reg <- temp
                    zeroUpd       = zAlu;
                end
            end

            oprBbl, oprLdm: begin
                aluEnableNext = 1'b1;
                aluOpNext     = opr;
                aluSelNext    = selImm;
                if (isX3) begin
                    accWeNext    = 1'b1;
                    stackPopNext = (opr == oprBbl);
                    if (opr == oprLdm) begin
                        zeroUpd = zAlu;
                    end
                end
            end

            // ----------------------------------------
            // Accumulator / carry group
            // ----------------------------------------
            oprAccGrp: begin
                aluEnableNext = 1'b1;
                aluOpNext     = oprAccGrp;
                aluSubOpNext  = opa;
                if (isX3) begin
                    accWeNext = (opa <= opaKbp)
                        && !(opa inside {opaClc, opaCmc, opaStc});
                    case (opa)
                        opaClb, opaClc, opaTcc, opaTcs:         carryUpd = cClear;
                        opaCmc:                                 carryUpd = cInvert;
                        opaStc:                                 carryUpd = cSet;
                        opaIac, opaRal, opaRar, opaDac, opaDaa: carryUpd = cAlu;
                        default:                                carryUpd = cKeep;
                    endcase
                    if (opa inside {opaClb, opaIac, opaCma, opaTcc, opaDac, opaDaa, opaKbp}) begin
                        zeroUpd = zAlu;
                    end
                end
            end

            default: begin
                // NOP and unused codes
            end
        endcase

        pcLoadDataNext = (jumpNext || jumpCondNext) ? immAddr : '0;
    end

endmodule

// ==== isaPkg.sv ====
package isaPkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int nibbleW = 4;
    localparam int cycleW  = 3;
    localparam int addrW   = 12;

    // ----------------------------------------
    // Opcodes (OPR nibble)
    // ----------------------------------------
    localparam logic [3:0] oprNop    = 4'h0;
    localparam logic [3:0] oprJcn    = 4'h1;
    localparam logic [3:0] oprFimSrc = 4'h2;  // opa[0] picks SRC
    localparam logic [3:0] oprFinJin = 4'h3;  // opa[0] picks JIN
    localparam logic [3:0] oprJun    = 4'h4;
    localparam logic [3:0] oprJms    = 4'h5;
    localparam logic [3:0] oprInc    = 4'h6;
    localparam logic [3:0] oprAdd    = 4'h8;
    localparam logic [3:0] oprSub    = 4'h9;
    localparam logic [3:0] oprLd     = 4'hA;
    localparam logic [3:0] oprXch    = 4'hB;
    localparam logic [3:0] oprBbl    = 4'hC;
    localparam logic [3:0] oprLdm    = 4'hD;
    localparam logic [3:0] oprAccGrp = 4'hF;

    // Accumulator group subcodes
    localparam logic [3:0] opaClb = 4'h0;
    localparam logic [3:0] opaClc = 4'h1;
    localparam logic [3:0] opaIac = 4'h2;
    localparam logic [3:0] opaCmc = 4'h3;
    localparam logic [3:0] opaCma = 4'h4;
    localparam logic [3:0] opaRal = 4'h5;
    localparam logic [3:0] opaRar = 4'h6;
    localparam logic [3:0] opaTcc = 4'h7;
    localparam logic [3:0] opaDac = 4'h8;
    localparam logic [3:0] opaTcs = 4'h9;
    localparam logic [3:0] opaStc = 4'hA;
    localparam logic [3:0] opaDaa = 4'hB;
    localparam logic [3:0] opaKbp = 4'hC;  // Last defined code

    // Machine cycles that the decoder acts on
    localparam logic [2:0] cycX1 = 3'd5;
    localparam logic [2:0] cycX3 = 3'd7;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build the decoder testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module decoderTop_tb -f decoderTop.f -o decoderSim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/decoderSim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; } || grep -q ">>> PASS" sim.log
